/* hw/adc_mon_consts.svh */
`ifndef ADC_MON_CONSTS_SVH
`define ADC_MON_CONSTS_SVH

// converter sample width, signed two's complement
`define ADC_MON_ADC_BITS 14

// default window counter width
// 16 bits gives a window of 65536 adc_clk cycles
`define ADC_MON_WIN_BITS 16

// width of the level event counter
`define ADC_MON_CNT_BITS 32

// width of the host command data word
`define ADC_MON_WORD_BITS 32

// opcode field width on the command port
`define ADC_MON_OP_BITS 3

`endif

/* hw/adc_mon_pkg.sv */
`default_nettype none

`include "adc_mon_consts.svh"

package adc_mon_pkg;

    // raw converter sample
    typedef logic signed [`ADC_MON_ADC_BITS-1:0] adc_sample_t;

    // magnitude drops the sign bit, full scale saturates to all ones
    typedef logic [`ADC_MON_ADC_BITS-2:0] adc_mag_t;

    // level event count as seen by the host
    typedef logic [`ADC_MON_CNT_BITS-1:0] level_count_t;

    // data word carried with a command strobe
    typedef logic [`ADC_MON_WORD_BITS-1:0] cmd_word_t;

    // host opcodes
    // codes 4 to 7 are not assigned and answer with an error
    typedef enum logic [`ADC_MON_OP_BITS-1:0] {
        OP_NOP       = 3'd0,
        OP_FREEZE    = 3'd1,
        OP_SET_MASK  = 3'd2,
        OP_SET_LEVEL = 3'd3
    } cmd_op_t;

endpackage

`default_nettype wire

/* hw/ovfl_window_timer.sv */
`default_nettype none

`include "adc_mon_consts.svh"

module ovfl_window_timer #(
    parameter int WIN_BITS = `ADC_MON_WIN_BITS
) (
    input  wire  adc_clk,
    input  wire  rst_n,
    output logic window_end
);

    // free running, wraps through zero after the all ones count
    logic [WIN_BITS-1:0] win_cnt;

    //////////////////////////////
    // window counter
    //////////////////////////////

    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            win_cnt <= '0;
        end
        else
        begin
            win_cnt <= win_cnt + 1'b1;
        end
    end

    // last cycle of the window
    assign window_end = (win_cnt == {WIN_BITS{1'b1}});

    // windows are at least two cycles long
    a_window_end_single: assert property (@(posedge adc_clk) disable iff (!rst_n)
        window_end |=> !window_end);

endmodule

`default_nettype wire

/* hw/ovfl_detector.sv */
`default_nettype none

`include "adc_mon_consts.svh"

module ovfl_detector #(
    parameter int WIN_BITS = `ADC_MON_WIN_BITS
) (
    input  wire                          adc_clk,
    input  wire                          rst_n,
    input  wire                          adc_ovfl,
    input  wire                          window_end,
    input  wire                          mask_load,
    input  wire adc_mon_pkg::cmd_word_t  held_word,
    output logic                         ovfl_flag
);

    // flagged samples in the current window
    // the last window cycle is never counted so WIN_BITS always holds the total
    logic [WIN_BITS-1:0] ovfl_acc;

    // host mask, picks which accumulator bits raise the flag
    logic [WIN_BITS-1:0] ovfl_mask;

    //////////////////////////////
    // mask register
    //////////////////////////////

    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            ovfl_mask <= '0;
        end
        else if (mask_load)
        begin
            ovfl_mask <= held_word[WIN_BITS-1:0];
        end
    end

    //////////////////////////////
    // accumulate and judge
    //////////////////////////////

    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            ovfl_acc  <= '0;
            ovfl_flag <= 1'b0;
        end
        else if (window_end)
        begin
            // sample at the window edge is dropped
            ovfl_flag <= |(ovfl_acc & ovfl_mask);
            ovfl_acc  <= '0;
        end
        else
        begin
            ovfl_flag <= 1'b0;
            ovfl_acc  <= ovfl_acc + {{(WIN_BITS-1){1'b0}}, adc_ovfl};
        end
    end

    // flag pulse lines up with the timer window edge
    a_flag_after_window: assert property (@(posedge adc_clk) disable iff (!rst_n)
        ovfl_flag |-> $past(window_end));

endmodule

`default_nettype wire

/* hw/level_counter.sv */
`default_nettype none

`include "adc_mon_consts.svh"

module level_counter (
    input  wire                            adc_clk,
    input  wire                            rst_n,
    input  wire adc_mon_pkg::adc_sample_t  adc_data,
    input  wire                            adc_ovfl,
    input  wire                            level_load,
    input  wire adc_mon_pkg::cmd_word_t    held_word,
    output adc_mon_pkg::level_count_t      adc_count
);

    localparam int MSB = `ADC_MON_ADC_BITS - 1;

    logic [MSB:0]           adc_abs;
    adc_mon_pkg::adc_mag_t  adc_mag;
    logic                   lvl_mode;
    adc_mon_pkg::adc_mag_t  lvl_thresh;
    logic                   lvl_hit;

    //////////////////////////////
    // sample magnitude
    //////////////////////////////

    always_comb
    begin
        adc_abs = adc_data[MSB] ? -adc_data : adc_data;
        // only the most negative code leaves the top bit set after negation
        if (adc_abs[MSB])
        begin
            adc_mag = '1;
        end
        else
        begin
            adc_mag = adc_abs[MSB-1:0];
        end
    end

    // mode 0 compares magnitude, mode 1 follows the converter flag
    assign lvl_hit = lvl_mode ? adc_ovfl : (adc_mag >= lvl_thresh);

    //////////////////////////////
    // mode and threshold
    //////////////////////////////

    // word layout is mode in bit 13 and threshold in bits 12:0
    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            lvl_mode   <= 1'b0;
            lvl_thresh <= '0;
        end
        else if (level_load)
        begin
            lvl_mode   <= held_word[MSB];
            lvl_thresh <= held_word[MSB-1:0];
        end
    end

    //////////////////////////////
    // event counter
    //////////////////////////////

    // a load clears the count, counting restarts on the next edge
    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            adc_count <= '0;
        end
        else if (level_load)
        begin
            adc_count <= '0;
        end
        else if (lvl_hit)
        begin
            adc_count <= adc_count + 1'b1;
        end
    end

    a_count_step: assert property (@(posedge adc_clk) disable iff (!rst_n)
        1'b1 |=> ((adc_count == $past(adc_count))
              || (adc_count == $past(adc_count) + 1'b1)
              || ($past(level_load) && (adc_count == '0))));

endmodule

`default_nettype wire

/* hw/cmd_sequencer.sv */
`default_nettype none

`include "adc_mon_consts.svh"

module cmd_sequencer (
    input  wire                          adc_clk,
    input  wire                          rst_n,
    input  wire                          cmd_valid,
    input  wire adc_mon_pkg::cmd_op_t    cmd_op,
    input  wire adc_mon_pkg::cmd_word_t  cmd_data,
    output adc_mon_pkg::cmd_word_t       held_word,
    output logic                         mask_load,
    output logic                         level_load,
    output logic                         cmd_err
);

    // IDLE waits for a freeze, HELD has a word ready for one set command
    typedef enum logic {
        IDLE = 1'b0,
        HELD = 1'b1
    } seq_state_t;

    seq_state_t state_q;
    seq_state_t state_d;
    logic       mask_load_d;
    logic       level_load_d;
    logic       cmd_err_d;

    //////////////////////////////
    // next state decode
    //////////////////////////////

    always_comb
    begin
        state_d      = state_q;
        mask_load_d  = 1'b0;
        level_load_d = 1'b0;
        cmd_err_d    = 1'b0;
        if (cmd_valid)
        begin
            case (cmd_op)
                adc_mon_pkg::OP_NOP:
                begin
                    state_d = state_q;
                end
                // a repeated freeze just refreshes the word and stays in HELD
                adc_mon_pkg::OP_FREEZE:
                begin
                    state_d = HELD;
                end
                adc_mon_pkg::OP_SET_MASK:
                begin
                    if (state_q == HELD)
                    begin
                        mask_load_d = 1'b1;
                        state_d     = IDLE;
                    end
                    else
                    begin
                        // set without a frozen word
                        cmd_err_d = 1'b1;
                    end
                end
                adc_mon_pkg::OP_SET_LEVEL:
                begin
                    if (state_q == HELD)
                    begin
                        level_load_d = 1'b1;
                        state_d      = IDLE;
                    end
                    else
                    begin
                        cmd_err_d = 1'b1;
                    end
                end
                // unassigned opcode, state is kept
                default:
                begin
                    cmd_err_d = 1'b1;
                end
            endcase
        end
    end

    //////////////////////////////
    // state and pulse registers
    //////////////////////////////

    // pulses are high for the single cycle after the command edge
    always_ff @(posedge adc_clk)
    begin
        if (!rst_n)
        begin
            state_q    <= IDLE;
            mask_load  <= 1'b0;
            level_load <= 1'b0;
            cmd_err    <= 1'b0;
        end
        else
        begin
            state_q    <= state_d;
            mask_load  <= mask_load_d;
            level_load <= level_load_d;
            cmd_err    <= cmd_err_d;
        end
    end

    // freeze captures the data word in either state
    always_ff @(posedge adc_clk)
    begin
        if (cmd_valid && (cmd_op == adc_mon_pkg::OP_FREEZE))
        begin
            held_word <= cmd_data;
        end
    end

    // every load pulse follows a cycle spent in HELD
    a_load_after_freeze: assert property (@(posedge adc_clk) disable iff (!rst_n)
        (mask_load || level_load) |-> ($past(state_q) == HELD));

endmodule

`default_nettype wire

/* hw/adc_mon_top.sv */
`default_nettype none

`include "adc_mon_consts.svh"

module adc_mon_top #(
    parameter int WIN_BITS = `ADC_MON_WIN_BITS
) (
    input  wire                             adc_clk,
    input  wire                             rst_n,

    // converter side
    input  wire adc_mon_pkg::adc_sample_t   adc_data,
    input  wire                             adc_ovfl,

    // host command port, strobed in the adc_clk domain
    input  wire                             cmd_valid,
    input  wire adc_mon_pkg::cmd_op_t       cmd_op,
    input  wire adc_mon_pkg::cmd_word_t     cmd_data,

    // results
    output wire                             ovfl_flag,
    output wire adc_mon_pkg::level_count_t  adc_count,
    output wire                             cmd_err
);

    // word captured by the last freeze
    wire adc_mon_pkg::cmd_word_t held_word;
    wire                         mask_load;
    wire                         level_load;
    wire                         window_end;

    //////////////////////////////
    // host command sequencing
    //////////////////////////////

    cmd_sequencer cmd_sequencer_i (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .held_word  (held_word),
        .mask_load  (mask_load),
        .level_load (level_load),
        .cmd_err    (cmd_err)
    );

    //////////////////////////////
    // overflow detection
    //////////////////////////////

    ovfl_window_timer #(
        .WIN_BITS   (WIN_BITS)
    ) ovfl_window_timer_i (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .window_end (window_end)
    );

    ovfl_detector #(
        .WIN_BITS   (WIN_BITS)
    ) ovfl_detector_i (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .adc_ovfl   (adc_ovfl),
        .window_end (window_end),
        .mask_load  (mask_load),
        .held_word  (held_word),
        .ovfl_flag  (ovfl_flag)
    );

    //////////////////////////////
    // level detection
    //////////////////////////////

    level_counter level_counter_i (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_ovfl   (adc_ovfl),
        .level_load (level_load),
        .held_word  (held_word),
        .adc_count  (adc_count)
    );

endmodule

`default_nettype wire

/* test/tb_adc_mon.sv */
`default_nettype none

`include "adc_mon_consts.svh"

module tb_adc_mon;

    localparam int WIN_BITS = 8;
    localparam int WIN_MAX  = (1 << WIN_BITS) - 1;
    localparam int MAG_MAX  = (1 << (`ADC_MON_ADC_BITS - 1)) - 1;

    logic                       adc_clk;
    logic                       rst_n;
    adc_mon_pkg::adc_sample_t   adc_data;
    logic                       adc_ovfl;
    logic                       cmd_valid;
    adc_mon_pkg::cmd_op_t       cmd_op;
    adc_mon_pkg::cmd_word_t     cmd_data;
    logic                       ovfl_flag;
    adc_mon_pkg::level_count_t  adc_count;
    logic                       cmd_err;

    // stimulus state
    logic                       rst_next;
    logic [15:0]                lfsr_q;
    int                         ovfl_density;   // flagged samples per 8, 0 to 8
    string                      test_name;

    // reference model registers
    logic                       m_state;        // 0 idle, 1 word held
    adc_mon_pkg::cmd_word_t     m_held;
    logic                       m_mask_ld;
    logic                       m_level_ld;
    logic                       m_err;
    int                         m_timer;
    int                         m_acc;
    logic [WIN_BITS-1:0]        m_mask;
    logic                       m_flag;
    logic                       m_mode;
    int                         m_thresh;
    adc_mon_pkg::level_count_t  m_count;

    adc_mon_top #(
        .WIN_BITS   (WIN_BITS)
    ) adc_mon_top_i (
        .adc_clk    (adc_clk),
        .rst_n      (rst_n),
        .adc_data   (adc_data),
        .adc_ovfl   (adc_ovfl),
        .cmd_valid  (cmd_valid),
        .cmd_op     (cmd_op),
        .cmd_data   (cmd_data),
        .ovfl_flag  (ovfl_flag),
        .adc_count  (adc_count),
        .cmd_err    (cmd_err)
    );

    initial
    begin
        adc_clk = 1'b0;
        forever #4 adc_clk = ~adc_clk;
    end

    //////////////////////////////
    // random source
    //////////////////////////////

    // 16 bit galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // one lfsr step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        int          i;
        v = '0;
        for (i = 0; i < n; i++)
        begin
            lfsr_q = lfsr_step(lfsr_q);
            v      = {v[30:0], lfsr_q[0]};
        end
        return v;
    endfunction

    // absolute value, full negative scale clips to the top magnitude
    function automatic int sample_mag(input adc_mon_pkg::adc_sample_t s);
        int v;
        v = int'(s);
        if (v < 0)
        begin
            v = -v;
        end
        if (v > MAG_MAX)
        begin
            v = MAG_MAX;
        end
        return v;
    endfunction

    // mode in bit 13, threshold below it
    function automatic adc_mon_pkg::cmd_word_t level_word(input logic mode,
                                                          input logic [12:0] thresh);
        return {18'd0, mode, thresh};
    endfunction

    //////////////////////////////
    // compare tasks
    //////////////////////////////

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s expected %0b actual %0b", name, exp, act);
            $display("Checks failed");
            $fatal(1, "flag mismatch");
        end
    endtask

    task automatic check_count(input string name, input adc_mon_pkg::level_count_t exp,
                               input adc_mon_pkg::level_count_t act);
        if (act !== exp)
        begin
            $display("CHECK FAILED %s expected %0d actual %0d", name, exp, act);
            $display("Checks failed");
            $fatal(1, "count mismatch");
        end
    endtask

    //////////////////////////////
    // reference model
    //////////////////////////////

    // one clock edge, consumers first so every block sees pre-edge values
    task automatic model_edge();
        logic hit;
        if (!rst_n)
        begin
            m_state    = 1'b0;
            m_mask_ld  = 1'b0;
            m_level_ld = 1'b0;
            m_err      = 1'b0;
            m_timer    = 0;
            m_acc      = 0;
            m_mask     = '0;
            m_flag     = 1'b0;
            m_mode     = 1'b0;
            m_thresh   = 0;
            m_count    = '0;
        end
        else
        begin
            // level count
            hit = m_mode ? adc_ovfl : (sample_mag(adc_data) >= m_thresh);
            if (m_level_ld)
            begin
                m_mode   = m_held[13];
                m_thresh = int'(m_held[12:0]);
                m_count  = '0;
            end
            else if (hit)
            begin
                m_count = m_count + 1;
            end
            // overflow window, edge sample is not counted
            if (m_timer == WIN_MAX)
            begin
                m_flag = ((m_acc & int'(m_mask)) != 0);
                m_acc  = 0;
            end
            else
            begin
                m_flag = 1'b0;
                m_acc  = m_acc + int'(adc_ovfl);
            end
            if (m_mask_ld)
            begin
                m_mask = m_held[WIN_BITS-1:0];
            end
            m_timer = (m_timer + 1) % (WIN_MAX + 1);
            // freeze then set
            m_mask_ld  = 1'b0;
            m_level_ld = 1'b0;
            m_err      = 1'b0;
            if (cmd_valid)
            begin
                case (cmd_op)
                    adc_mon_pkg::OP_NOP:
                    begin
                    end
                    adc_mon_pkg::OP_FREEZE:
                    begin
                        m_held  = cmd_data;
                        m_state = 1'b1;
                    end
                    adc_mon_pkg::OP_SET_MASK, adc_mon_pkg::OP_SET_LEVEL:
                    begin
                        if (m_state)
                        begin
                            m_mask_ld  = (cmd_op == adc_mon_pkg::OP_SET_MASK);
                            m_level_ld = (cmd_op == adc_mon_pkg::OP_SET_LEVEL);
                            m_state    = 1'b0;
                        end
                        else
                        begin
                            m_err = 1'b1;
                        end
                    end
                    default:
                    begin
                        m_err = 1'b1;
                    end
                endcase
            end
        end
    endtask

    //////////////////////////////
    // stimulus
    //////////////////////////////

    // model the edge, drive the next inputs, compare at the falling edge
    task automatic drive_cycle(input logic valid, input adc_mon_pkg::cmd_op_t op,
                               input adc_mon_pkg::cmd_word_t data);
        logic [31:0]              r;
        adc_mon_pkg::adc_sample_t smp;
        @(posedge adc_clk);
        model_edge();
        r   = rand_bits(`ADC_MON_ADC_BITS);
        smp = r[`ADC_MON_ADC_BITS-1:0];
        // full negative scale now and then
        if (rand_bits(4) == 32'd0)
        begin
            smp = {1'b1, {(`ADC_MON_ADC_BITS-1){1'b0}}};
        end
        rst_n     <= rst_next;
        adc_data  <= smp;
        adc_ovfl  <= (rand_bits(3) < ovfl_density);
        cmd_valid <= valid;
        cmd_op    <= op;
        cmd_data  <= data;
        @(negedge adc_clk);
        check_flag({test_name, " ovfl_flag"}, m_flag, ovfl_flag);
        check_flag({test_name, " cmd_err"}, m_err, cmd_err);
        check_count({test_name, " adc_count"}, m_count, adc_count);
    endtask

    task automatic run_cycles(input int n);
        int i;
        for (i = 0; i < n; i++)
        begin
            drive_cycle(1'b0, adc_mon_pkg::OP_NOP, rand_bits(32));
        end
    endtask

    task automatic send_cmd(input adc_mon_pkg::cmd_op_t op, input adc_mon_pkg::cmd_word_t data);
        drive_cycle(1'b1, op, data);
    endtask

    // run until the timer marks a window end, then past the flag cycle
    task automatic wait_window_end(input int limit);
        int n;
        n = 0;
        while (adc_mon_top_i.ovfl_window_timer_i.window_end !== 1'b1)
        begin
            if (n >= limit)
            begin
                $display("timed out waiting for a window end in %s", test_name);
                $display("Checks failed");
                $fatal(1, "window timeout");
            end
            run_cycles(1);
            n++;
        end
        run_cycles(2);
    endtask

    //////////////////////////////
    // test sequence
    //////////////////////////////

    initial
    begin
        int          dens [5];
        logic [31:0] r;
        int          c;
        dens         = '{0, 1, 3, 8, 2};
        rst_n        <= 1'b0;
        adc_data     <= '0;
        adc_ovfl     <= 1'b0;
        cmd_valid    <= 1'b0;
        cmd_op       <= adc_mon_pkg::OP_NOP;
        cmd_data     <= '0;
        rst_next     = 1'b0;
        m_held       = '0;
        lfsr_q       = 16'd67;
        ovfl_density = 2;

        // reset low for two edges
        test_name = "reset";
        run_cycles(1);
        rst_next = 1'b1;
        run_cycles(1);
        check_count("reset adc_count", '0, adc_count);
        check_flag("reset ovfl_flag", 1'b0, ovfl_flag);
        // mask is zero so the first window raises nothing
        wait_window_end(WIN_MAX + 4);

        test_name = "level_mode0";
        r = rand_bits(13);
        send_cmd(adc_mon_pkg::OP_FREEZE, level_word(1'b0, r[12:0]));
        send_cmd(adc_mon_pkg::OP_SET_LEVEL, rand_bits(32));
        run_cycles(2);
        check_count("level_mode0 clear", '0, adc_count);
        run_cycles(300);

        test_name    = "level_mode1";
        ovfl_density = 3;
        send_cmd(adc_mon_pkg::OP_FREEZE, level_word(1'b1, 13'd0));
        send_cmd(adc_mon_pkg::OP_SET_LEVEL, '0);
        run_cycles(120);
        // reload clears at the edge after the load pulse
        send_cmd(adc_mon_pkg::OP_FREEZE, level_word(1'b1, 13'h1fff));
        send_cmd(adc_mon_pkg::OP_SET_LEVEL, '0);
        run_cycles(2);
        check_count("level_reload", '0, adc_count);
        run_cycles(40);

        test_name = "ovfl_mask";
        r = rand_bits(WIN_BITS);
        send_cmd(adc_mon_pkg::OP_FREEZE, {24'd0, r[7:0] | 8'h01});
        send_cmd(adc_mon_pkg::OP_SET_MASK, '0);
        foreach (dens[i])
        begin
            ovfl_density = dens[i];
            wait_window_end(WIN_MAX + 4);
        end

        test_name = "cmd_err";
        ovfl_density = 2;
        // the second freeze replaces the word and a bad code while held changes nothing
        send_cmd(adc_mon_pkg::OP_FREEZE, level_word(1'b0, 13'd100));
        send_cmd(adc_mon_pkg::OP_FREEZE, level_word(1'b0, 13'd4096));
        send_cmd(adc_mon_pkg::cmd_op_t'(3'd6), '0);
        send_cmd(adc_mon_pkg::OP_SET_LEVEL, '0);
        run_cycles(100);
        // low byte of the held word is zero so a stray mask load would silence the flag
        send_cmd(adc_mon_pkg::OP_SET_MASK, 32'h0000_00ff);
        run_cycles(1);
        check_flag("cmd_err set_mask idle", 1'b1, cmd_err);
        run_cycles(1);
        check_flag("cmd_err single pulse", 1'b0, cmd_err);
        send_cmd(adc_mon_pkg::OP_SET_LEVEL, level_word(1'b0, 13'd5));
        send_cmd(adc_mon_pkg::OP_NOP, '1);
        // unassigned codes in idle
        for (c = 4; c < 8; c++)
        begin
            send_cmd(adc_mon_pkg::cmd_op_t'(3'(c)), rand_bits(32));
        end
        // every sample flagged so a full window fills the accumulator
        ovfl_density = 8;
        wait_window_end(WIN_MAX + 4);
        wait_window_end(WIN_MAX + 4);

        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

/* sources.f */
+incdir+hw
hw/adc_mon_pkg.sv
hw/ovfl_window_timer.sv
hw/ovfl_detector.sv
hw/level_counter.sv
hw/cmd_sequencer.sv
hw/adc_mon_top.sv
test/tb_adc_mon.sv

/* run_sim.sh */
#!/usr/bin/env bash
# build the testbench with Verilator, run it and judge the log
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log

verilator --binary --timing --assert \
    -f sources.f \
    --top-module tb_adc_mon \
    -o tb_adc_mon_sim \
    && ./obj_dir/tb_adc_mon_sim > sim.log 2>&1 \
    || echo "build or simulation error"

grep -q "All checks passed" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
